/* compile.f */
csr_pkg.sv
csr_ctrl.sv
csr_status.sv
csr_trap_regs.sv
csr_counter.sv
csr_read_mux.sv
csr_top.sv
csr_chk.sv
tb_csr.sv

/* csr_chk.sv */
`timescale 1ns/1ps
module csr_chk (
  input logic              clk,
  input logic              rst_n,
  input csr_pkg::csr_req_t req,
  input csr_pkg::csr_sel_t wr_sel,
  input csr_pkg::csr_sel_t rd_sel
);

  // one register per strobe at most
  a_wr_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(wr_sel))
    else $error("write selects are not one-hot");

  a_wr_needs_ena: assert property (@(posedge clk) disable iff (!rst_n)
    !req.ena |-> (wr_sel == '0))
    else $error("write select set while req.ena is low");

  a_rd_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(rd_sel))
    else $error("read selects are not one-hot");

endmodule

bind csr_ctrl csr_chk u_chk (
  .clk    (clk),
  .rst_n  (rst_n),
  .req    (req),
  .wr_sel (wr_sel),
  .rd_sel (rd_sel)
);

/* csr_counter.sv */
`timescale 1ns/1ps
module csr_counter (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             inc,
  input  csr_pkg::cnt_wr_t wr,
  input  csr_pkg::xlen_t   wdata,
  output csr_pkg::xlen_t   lo,
  output csr_pkg::xlen_t   hi
);
  import csr_pkg::*;

  logic lo_full; // carry out of the low word

  assign lo_full = (lo == {XLEN{1'b1}});

  // a written word takes wdata and skips its increment
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lo <= '0;
    end else if (wr.lo) begin
      lo <= wdata;
    end else if (inc) begin
      lo <= lo + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hi <= '0;
    end else if (wr.hi) begin
      hi <= wdata;
    end else if (inc && lo_full) begin
      hi <= hi + 1'b1;
    end
  end

endmodule

/* csr_ctrl.sv */
`timescale 1ns/1ps
module csr_ctrl (
  input  logic              clk,
  input  logic              rst_n,
  input  csr_pkg::csr_req_t req,
  input  csr_pkg::xlen_t    wdata,
  input  logic              instret_ena,
  output csr_pkg::csr_sel_t wr_sel,
  output csr_pkg::csr_sel_t rd_sel,
  output csr_pkg::cnt_wr_t  cyc_wr,
  output csr_pkg::cnt_wr_t  ir_wr,
  output logic              cyc_inc,
  output logic              ir_inc,
  output csr_pkg::xlen_t    counterstop,
  output logic              tm_stop
);
  import csr_pkg::*;

  csr_sel_t   hit;    // raw index match, before strobes
  logic       wr_stb;
  logic [2:0] stop_r; // 0 cycle, 1 mtime, 2 instret

  // the only place the index is compared
  always_comb begin
    hit.mstatus     = (req.idx == IDX_MSTATUS);
    hit.misa        = (req.idx == IDX_MISA);
    hit.mie         = (req.idx == IDX_MIE);
    hit.mtvec       = (req.idx == IDX_MTVEC);
    hit.mscratch    = (req.idx == IDX_MSCRATCH);
    hit.mepc        = (req.idx == IDX_MEPC);
    hit.mcause      = (req.idx == IDX_MCAUSE);
    hit.mbadaddr    = (req.idx == IDX_MBADADDR);
    hit.mip         = (req.idx == IDX_MIP);
    hit.mcycle      = (req.idx == IDX_MCYCLE);
    hit.mcycleh     = (req.idx == IDX_MCYCLEH);
    hit.minstret    = (req.idx == IDX_MINSTRET);
    hit.minstreth   = (req.idx == IDX_MINSTRETH);
    hit.counterstop = (req.idx == IDX_COUNTERSTOP);
    hit.mvendorid   = (req.idx == IDX_MVENDORID);
    hit.marchid     = (req.idx == IDX_MARCHID);
    hit.mimpid      = (req.idx == IDX_MIMPID);
    hit.mhartid     = (req.idx == IDX_MHARTID);
  end

  assign wr_stb = req.ena & req.wr_en;
  assign wr_sel = hit & {$bits(csr_sel_t){wr_stb}};
  assign rd_sel = hit & {$bits(csr_sel_t){req.rd_en}}; // reads ignore ena

  // counter-stop register, only 3 bits kept
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stop_r <= 3'b000;
    end else if (wr_sel.counterstop) begin
      stop_r <= wdata[2:0];
    end
  end

  assign counterstop = {{(XLEN-3){1'b0}}, stop_r};
  assign tm_stop     = stop_r[1];

  // word writes to the two counters
  assign cyc_wr.lo = wr_sel.mcycle;
  assign cyc_wr.hi = wr_sel.mcycleh;
  assign ir_wr.lo  = wr_sel.minstret;
  assign ir_wr.hi  = wr_sel.minstreth;

  assign cyc_inc = ~stop_r[0];               // free running
  assign ir_inc  = instret_ena & ~stop_r[2]; // one per retired instr

endmodule

/* csr_pkg.sv */
package csr_pkg;

  localparam int XLEN      = 32;
  localparam int PC_SIZE   = 32;
  localparam int ADDR_SIZE = 32;
  localparam int HART_ID_W = 1;
  localparam int CSR_IDX_W = 12;

  // machine-mode csr indices
  localparam logic [CSR_IDX_W-1:0] IDX_MSTATUS     = 12'h300;
  localparam logic [CSR_IDX_W-1:0] IDX_MISA        = 12'h301;
  localparam logic [CSR_IDX_W-1:0] IDX_MIE         = 12'h304;
  localparam logic [CSR_IDX_W-1:0] IDX_MTVEC       = 12'h305;
  localparam logic [CSR_IDX_W-1:0] IDX_MSCRATCH    = 12'h340;
  localparam logic [CSR_IDX_W-1:0] IDX_MEPC        = 12'h341;
  localparam logic [CSR_IDX_W-1:0] IDX_MCAUSE      = 12'h342;
  localparam logic [CSR_IDX_W-1:0] IDX_MBADADDR    = 12'h343;
  localparam logic [CSR_IDX_W-1:0] IDX_MIP         = 12'h344;
  localparam logic [CSR_IDX_W-1:0] IDX_MCYCLE      = 12'hB00;
  localparam logic [CSR_IDX_W-1:0] IDX_MCYCLEH     = 12'hB80;
  localparam logic [CSR_IDX_W-1:0] IDX_MINSTRET    = 12'hB02;
  localparam logic [CSR_IDX_W-1:0] IDX_MINSTRETH   = 12'hB82;
  localparam logic [CSR_IDX_W-1:0] IDX_COUNTERSTOP = 12'hBFF; // custom
  localparam logic [CSR_IDX_W-1:0] IDX_MVENDORID   = 12'hF11;
  localparam logic [CSR_IDX_W-1:0] IDX_MARCHID     = 12'hF12;
  localparam logic [CSR_IDX_W-1:0] IDX_MIMPID      = 12'hF13;
  localparam logic [CSR_IDX_W-1:0] IDX_MHARTID     = 12'hF14;

  // identity values
  localparam logic [XLEN-1:0] MISA_VAL      = 32'h4000_1105; // rv32, a c i m
  localparam logic [XLEN-1:0] MVENDORID_VAL = 32'h0000_0536;
  localparam logic [XLEN-1:0] MARCHID_VAL   = 32'h0000_E203;
  localparam logic [XLEN-1:0] MIMPID_VAL    = 32'h0000_0001;

  // bit positions in mie/mip and mstatus
  localparam int MEIE_BIT = 11;
  localparam int MTIE_BIT = 7;
  localparam int MSIE_BIT = 3;
  localparam int MPIE_BIT = 7;
  localparam int MIE_BIT  = 3;

  typedef logic [XLEN-1:0] xlen_t;

  typedef struct packed {
    logic                 ena;
    logic                 wr_en;
    logic                 rd_en;
    logic [CSR_IDX_W-1:0] idx;
  } csr_req_t;

  // trap commit from the core
  typedef struct packed {
    logic                 status_ena; // trap entry
    logic                 mret_ena;
    logic                 epc_ena;
    logic [PC_SIZE-1:0]   epc;
    logic                 cause_ena;
    xlen_t                cause;
    logic                 badaddr_ena;
    logic [ADDR_SIZE-1:0] badaddr;
  } cmt_t;

  typedef struct packed {
    logic ext;
    logic sft;
    logic tmr;
  } irq_t;

  typedef struct packed {
    logic global_mie;
    logic meie;
    logic mtie;
    logic msie;
  } int_en_t;

  // one flag per csr, used for write strobes and read selects
  typedef struct packed {
    logic mstatus;
    logic misa;
    logic mie;
    logic mtvec;
    logic mscratch;
    logic mepc;
    logic mcause;
    logic mbadaddr;
    logic mip;
    logic mcycle;
    logic mcycleh;
    logic minstret;
    logic minstreth;
    logic counterstop;
    logic mvendorid;
    logic marchid;
    logic mimpid;
    logic mhartid;
  } csr_sel_t;

  typedef struct packed {
    logic lo;
    logic hi;
  } cnt_wr_t;

endpackage

/* csr_read_mux.sv */
`timescale 1ns/1ps
module csr_read_mux (
  input  csr_pkg::csr_sel_t            rd_sel,
  input  csr_pkg::xlen_t               mstatus,
  input  csr_pkg::xlen_t               mie,
  input  csr_pkg::xlen_t               mip,
  input  csr_pkg::xlen_t               mtvec,
  input  csr_pkg::xlen_t               mscratch,
  input  csr_pkg::xlen_t               mepc,
  input  csr_pkg::xlen_t               mcause,
  input  csr_pkg::xlen_t               mbadaddr,
  input  csr_pkg::xlen_t               mcycle,
  input  csr_pkg::xlen_t               mcycleh,
  input  csr_pkg::xlen_t               minstret,
  input  csr_pkg::xlen_t               minstreth,
  input  csr_pkg::xlen_t               counterstop,
  input  logic [csr_pkg::HART_ID_W-1:0] core_mhartid,
  output csr_pkg::xlen_t               rdata
);
  import csr_pkg::*;

  xlen_t mhartid;

  assign mhartid = {{(XLEN-HART_ID_W){1'b0}}, core_mhartid};

  // selects are one-hot, so an OR of masked values is enough
  assign rdata = ({XLEN{rd_sel.mstatus}}     & mstatus)
               | ({XLEN{rd_sel.misa}}        & MISA_VAL)
               | ({XLEN{rd_sel.mie}}         & mie)
               | ({XLEN{rd_sel.mtvec}}       & mtvec)
               | ({XLEN{rd_sel.mscratch}}    & mscratch)
               | ({XLEN{rd_sel.mepc}}        & mepc)
               | ({XLEN{rd_sel.mcause}}      & mcause)
               | ({XLEN{rd_sel.mbadaddr}}    & mbadaddr)
               | ({XLEN{rd_sel.mip}}         & mip)
               | ({XLEN{rd_sel.mcycle}}      & mcycle)
               | ({XLEN{rd_sel.mcycleh}}     & mcycleh)
               | ({XLEN{rd_sel.minstret}}    & minstret)
               | ({XLEN{rd_sel.minstreth}}   & minstreth)
               | ({XLEN{rd_sel.counterstop}} & counterstop)
               | ({XLEN{rd_sel.mvendorid}}   & MVENDORID_VAL)
               | ({XLEN{rd_sel.marchid}}     & MARCHID_VAL)
               | ({XLEN{rd_sel.mimpid}}      & MIMPID_VAL)
               | ({XLEN{rd_sel.mhartid}}     & mhartid);

endmodule

/* csr_status.sv */
`timescale 1ns/1ps
module csr_status (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              wr_mstatus,
  input  logic              wr_mie,
  input  csr_pkg::xlen_t    wdata,
  input  csr_pkg::cmt_t     cmt,
  input  csr_pkg::irq_t     irq,
  output csr_pkg::xlen_t    mstatus,
  output csr_pkg::xlen_t    mie,
  output csr_pkg::xlen_t    mip,
  output csr_pkg::int_en_t  int_en
);
  import csr_pkg::*;

  logic mie_r;  // global enable
  logic mpie_r; // value of mie before the trap
  logic meie_r;
  logic mtie_r;
  logic msie_r;
  irq_t ip_r;   // pending bits, sampled every cycle

  // trap entry beats mret, mret beats a csr write
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mie_r  <= 1'b0;
      mpie_r <= 1'b0;
    end else if (cmt.status_ena) begin
      mpie_r <= mie_r;
      mie_r  <= 1'b0;
    end else if (cmt.mret_ena) begin
      mie_r  <= mpie_r;
      mpie_r <= 1'b1;
    end else if (wr_mstatus) begin
      mie_r  <= wdata[MIE_BIT];
      mpie_r <= wdata[MPIE_BIT];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      meie_r <= 1'b0;
      mtie_r <= 1'b0;
      msie_r <= 1'b0;
    end else if (wr_mie) begin
      meie_r <= wdata[MEIE_BIT];
      mtie_r <= wdata[MTIE_BIT];
      msie_r <= wdata[MSIE_BIT];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ip_r <= '0;
    end else begin
      ip_r <= irq;
    end
  end

  always_comb begin
    mstatus           = '0;
    mstatus[12:11]    = 2'b11; // mpp, machine mode only
    mstatus[MPIE_BIT] = mpie_r;
    mstatus[MIE_BIT]  = mie_r;
    mie               = '0;
    mie[MEIE_BIT]     = meie_r;
    mie[MTIE_BIT]     = mtie_r;
    mie[MSIE_BIT]     = msie_r;
    mip               = '0;
    mip[MEIE_BIT]     = ip_r.ext; // same positions as the enables
    mip[MTIE_BIT]     = ip_r.tmr;
    mip[MSIE_BIT]     = ip_r.sft;
  end

  assign int_en.global_mie = mie_r;
  assign int_en.meie       = meie_r;
  assign int_en.mtie       = mtie_r;
  assign int_en.msie       = msie_r;

endmodule

/* csr_top.sv */
`timescale 1ns/1ps
module csr_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  csr_pkg::csr_req_t             req,
  input  csr_pkg::xlen_t                wdata,
  input  csr_pkg::cmt_t                 cmt,
  input  logic                          instret_ena,
  input  csr_pkg::irq_t                 irq,
  input  logic [csr_pkg::HART_ID_W-1:0] core_mhartid,
  output csr_pkg::xlen_t                rdata,
  output csr_pkg::int_en_t              int_en,
  output csr_pkg::xlen_t                mtvec,
  output csr_pkg::xlen_t                mepc,
  output logic                          tm_stop
);
  import csr_pkg::*;

  csr_sel_t wr_sel;
  csr_sel_t rd_sel;
  cnt_wr_t  cyc_wr;
  cnt_wr_t  ir_wr;
  logic     cyc_inc;
  logic     ir_inc;
  xlen_t    counterstop;
  xlen_t    mstatus;
  xlen_t    mie;
  xlen_t    mip;
  xlen_t    mscratch;
  xlen_t    mcause;
  xlen_t    mbadaddr;
  xlen_t    mcycle;
  xlen_t    mcycleh;
  xlen_t    minstret;
  xlen_t    minstreth;

  csr_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (req),
    .wdata       (wdata),
    .instret_ena (instret_ena),
    .wr_sel      (wr_sel),
    .rd_sel      (rd_sel),
    .cyc_wr      (cyc_wr),
    .ir_wr       (ir_wr),
    .cyc_inc     (cyc_inc),
    .ir_inc      (ir_inc),
    .counterstop (counterstop),
    .tm_stop     (tm_stop)
  );

  csr_status u_status (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_mstatus (wr_sel.mstatus),
    .wr_mie     (wr_sel.mie),
    .wdata      (wdata),
    .cmt        (cmt),
    .irq        (irq),
    .mstatus    (mstatus),
    .mie        (mie),
    .mip        (mip),
    .int_en     (int_en)
  );

  csr_trap_regs u_trap (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_sel   (wr_sel),
    .wdata    (wdata),
    .cmt      (cmt),
    .mtvec    (mtvec),
    .mscratch (mscratch),
    .mepc     (mepc),
    .mcause   (mcause),
    .mbadaddr (mbadaddr)
  );

  csr_counter u_cycle (
    .clk   (clk),
    .rst_n (rst_n),
    .inc   (cyc_inc),
    .wr    (cyc_wr),
    .wdata (wdata),
    .lo    (mcycle),
    .hi    (mcycleh)
  );

  csr_counter u_instret (
    .clk   (clk),
    .rst_n (rst_n),
    .inc   (ir_inc),
    .wr    (ir_wr),
    .wdata (wdata),
    .lo    (minstret),
    .hi    (minstreth)
  );

  csr_read_mux u_rmux (
    .rd_sel       (rd_sel),
    .mstatus      (mstatus),
    .mie          (mie),
    .mip          (mip),
    .mtvec        (mtvec),
    .mscratch     (mscratch),
    .mepc         (mepc),
    .mcause       (mcause),
    .mbadaddr     (mbadaddr),
    .mcycle       (mcycle),
    .mcycleh      (mcycleh),
    .minstret     (minstret),
    .minstreth    (minstreth),
    .counterstop  (counterstop),
    .core_mhartid (core_mhartid),
    .rdata        (rdata)
  );

endmodule

/* csr_trap_regs.sv */
`timescale 1ns/1ps
module csr_trap_regs (
  input  logic              clk,
  input  logic              rst_n,
  input  csr_pkg::csr_sel_t wr_sel,
  input  csr_pkg::xlen_t    wdata,
  input  csr_pkg::cmt_t     cmt,
  output csr_pkg::xlen_t    mtvec,
  output csr_pkg::xlen_t    mscratch,
  output csr_pkg::xlen_t    mepc,
  output csr_pkg::xlen_t    mcause,
  output csr_pkg::xlen_t    mbadaddr
);
  import csr_pkg::*;

  xlen_t                mtvec_r;
  xlen_t                mscratch_r;
  logic [PC_SIZE-1:1]   epc_r;     // bit 0 is always zero
  logic                 cause_irq; // bit 31, interrupt flag
  logic [3:0]           cause_code;
  logic [ADDR_SIZE-1:0] badaddr_r;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mtvec_r    <= '0;
      mscratch_r <= '0;
    end else begin
      if (wr_sel.mtvec) begin
        mtvec_r <= wdata;
      end
      if (wr_sel.mscratch) begin
        mscratch_r <= wdata;
      end
    end
  end

  // commit wins over a software write in the same cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      epc_r <= '0;
    end else if (cmt.epc_ena) begin
      epc_r <= cmt.epc[PC_SIZE-1:1];
    end else if (wr_sel.mepc) begin
      epc_r <= wdata[PC_SIZE-1:1];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cause_irq  <= 1'b0;
      cause_code <= 4'h0;
    end else if (cmt.cause_ena) begin
      cause_irq  <= cmt.cause[XLEN-1];
      cause_code <= cmt.cause[3:0];
    end else if (wr_sel.mcause) begin
      cause_irq  <= wdata[XLEN-1];
      cause_code <= wdata[3:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      badaddr_r <= '0;
    end else if (cmt.badaddr_ena) begin
      badaddr_r <= cmt.badaddr;
    end else if (wr_sel.mbadaddr) begin
      badaddr_r <= wdata[ADDR_SIZE-1:0];
    end
  end

  assign mtvec    = mtvec_r;
  assign mscratch = mscratch_r;
  assign mepc     = xlen_t'({epc_r, 1'b0});
  assign mcause   = {cause_irq, {(XLEN-5){1'b0}}, cause_code};
  assign mbadaddr = xlen_t'(badaddr_r);

endmodule

/* run.sh */
#!/bin/sh
# build and run the CSR testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_csr -f compile.f -o sim_csr
./obj_dir/sim_csr > sim.log 2>&1 || true
cat sim.log
if grep -q "all tests passed" sim.log; then
  echo "simulation result: PASS"
  exit 0
fi
echo "simulation result: FAIL"
exit 1

/* tb_csr.sv */
`timescale 1ns/1ps
module tb_csr;
  import csr_pkg::*;

  localparam int MAX_CYCLES = 2000;              // five tests need about 200 cycles
  localparam logic [CSR_IDX_W-1:0] IDX_UNKNOWN = 12'h7C0;

  logic                 clk;
  logic                 rst_n;
  csr_req_t             req;
  xlen_t                wdata;
  cmt_t                 cmt;
  logic                 instret_ena;
  irq_t                 irq;
  logic [HART_ID_W-1:0] core_mhartid;
  xlen_t                rdata;
  int_en_t              int_en;
  xlen_t                mtvec;
  xlen_t                mepc;
  logic                 tm_stop;

  int err_count = 0;
  int tests_run = 0;
  int tests_bad = 0;
  int cycle_cnt = 0;

  csr_top u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .req          (req),
    .wdata        (wdata),
    .cmt          (cmt),
    .instret_ena  (instret_ena),
    .irq          (irq),
    .core_mhartid (core_mhartid),
    .rdata        (rdata),
    .int_en       (int_en),
    .mtvec        (mtvec),
    .mepc         (mepc),
    .tm_stop      (tm_stop)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // hard stop in case a test never returns
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
      $display("tests failed");
      $finish;
    end
  end

  task automatic check_word(input xlen_t got, input xlen_t exp, input string what);
    if (got !== exp) begin
      err_count++;
      $display("[FAIL] %0t: %s read %08h, expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic check_int_en(input int_en_t got, input int_en_t exp, input string what);
    if (got !== exp) begin
      err_count++;
      $display("[FAIL] %0t: %s int_en %04b, expected %04b", $time, what, got, exp);
    end
  endtask

  // all bus tasks start and end on a falling edge
  task automatic drive_write(input logic ena, input logic [CSR_IDX_W-1:0] idx,
                             input xlen_t data);
    req       = '0;
    req.ena   = ena;
    req.wr_en = 1'b1;
    req.idx   = idx;
    wdata     = data;
    @(negedge clk);
    req   = '0;
    wdata = '0;
  endtask

  task automatic read_csr(input logic [CSR_IDX_W-1:0] idx, output xlen_t data);
    req       = '0;
    req.rd_en = 1'b1;
    req.idx   = idx;
    #1;
    data = rdata; // combinational, stable until the next rising edge
    @(negedge clk);
    req = '0;
  endtask

  task automatic expect_csr(input logic [CSR_IDX_W-1:0] idx, input xlen_t exp,
                            input string what);
    xlen_t got;
    read_csr(idx, got);
    check_word(got, exp, what);
  endtask

  task automatic end_test(input string name, input int errs_at_start);
    tests_run++;
    if (err_count != errs_at_start) begin
      tests_bad++;
      $display("test %s: %0d mismatches", name, err_count - errs_at_start);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  task automatic test_reset_values();
    int e0;
    e0 = err_count;
    expect_csr(IDX_MSTATUS, 32'h0000_1800, "mstatus");
    expect_csr(IDX_MTVEC, 32'h0, "mtvec");
    expect_csr(IDX_MSCRATCH, 32'h0, "mscratch");
    expect_csr(IDX_MEPC, 32'h0, "mepc");
    expect_csr(IDX_MISA, 32'h4000_1105, "misa");
    expect_csr(IDX_MVENDORID, 32'h0000_0536, "mvendorid");
    expect_csr(IDX_MARCHID, 32'h0000_E203, "marchid");
    expect_csr(IDX_MIMPID, 32'h0000_0001, "mimpid");
    expect_csr(IDX_MHARTID, 32'h0000_0001, "mhartid");
    expect_csr(IDX_UNKNOWN, 32'h0, "unknown index");
    check_int_en(int_en, 4'b0000, "after reset");
    check_word(xlen_t'(tm_stop), 32'h0, "tm_stop");
    end_test("reset_values", e0);
  endtask

  task automatic test_random_writes();
    int    e0;
    xlen_t d;
    xlen_t tvec;
    e0 = err_count;
    tvec = $urandom;
    drive_write(1'b1, IDX_MTVEC, tvec);
    expect_csr(IDX_MTVEC, tvec, "mtvec");
    check_word(mtvec, tvec, "mtvec port");
    d = $urandom;
    drive_write(1'b1, IDX_MSCRATCH, d);
    expect_csr(IDX_MSCRATCH, d, "mscratch");
    d = $urandom;
    drive_write(1'b1, IDX_MIE, d);
    expect_csr(IDX_MIE, d & 32'h0000_0888, "mie");      // only meie, mtie, msie
    d = $urandom;
    drive_write(1'b1, IDX_MCAUSE, d);
    expect_csr(IDX_MCAUSE, d & 32'h8000_000F, "mcause");
    d = $urandom;
    drive_write(1'b1, IDX_MEPC, d);
    expect_csr(IDX_MEPC, d & ~32'h1, "mepc");
    check_word(mepc, d & ~32'h1, "mepc port");
    d = $urandom;
    drive_write(1'b1, IDX_MBADADDR, d);
    expect_csr(IDX_MBADADDR, d, "mbadaddr");
    d = $urandom;
    drive_write(1'b1, IDX_MSTATUS, d);
    expect_csr(IDX_MSTATUS, 32'h0000_1800 | (d & 32'h88), "mstatus");
    drive_write(1'b1, IDX_MSTATUS, 32'h0);
    d = $urandom;
    drive_write(1'b1, IDX_COUNTERSTOP, d);
    expect_csr(IDX_COUNTERSTOP, d & 32'h7, "counterstop");
    check_word(xlen_t'(tm_stop), xlen_t'(d[1]), "tm_stop");
    drive_write(1'b1, IDX_COUNTERSTOP, 32'h0);
    // writes that must leave everything alone
    read_csr(IDX_MSCRATCH, d);
    drive_write(1'b0, IDX_MSCRATCH, ~d);
    expect_csr(IDX_MSCRATCH, d, "mscratch after write with ena low");
    drive_write(1'b1, IDX_UNKNOWN, ~d);
    expect_csr(IDX_MSCRATCH, d, "mscratch after unknown write");
    expect_csr(IDX_MTVEC, tvec, "mtvec after unknown write");
    expect_csr(IDX_UNKNOWN, 32'h0, "unknown index");
    end_test("random_writes", e0);
  endtask

  task automatic status_event(input logic trap, input logic mret, input logic sw_write);
    cmt.status_ena = trap;
    cmt.mret_ena   = mret;
    if (sw_write) begin
      drive_write(1'b1, IDX_MSTATUS, 32'h0);
    end else begin
      @(negedge clk);
    end
    cmt = '0;
  endtask

  // commit of epc, cause and badaddr against a software write to idx
  task automatic commit_vs_write(input logic [CSR_IDX_W-1:0] idx);
    xlen_t epc;
    xlen_t cause;
    xlen_t bad;
    epc   = $urandom;
    cause = $urandom;
    bad   = $urandom;
    cmt.epc_ena     = 1'b1;
    cmt.epc         = epc;
    cmt.cause_ena   = 1'b1;
    cmt.cause       = cause;
    cmt.badaddr_ena = 1'b1;
    cmt.badaddr     = bad;
    drive_write(1'b1, idx, ~(epc ^ cause ^ bad));
    cmt = '0;
    expect_csr(IDX_MEPC, epc & ~32'h1, "mepc after commit");
    expect_csr(IDX_MCAUSE, cause & 32'h8000_000F, "mcause after commit");
    expect_csr(IDX_MBADADDR, bad, "mbadaddr after commit");
  endtask

  task automatic test_trap_mret();
    int e0;
    e0 = err_count;
    drive_write(1'b1, IDX_MIE, 32'h0);
    drive_write(1'b1, IDX_MSTATUS, 32'h8);
    check_int_en(int_en, 4'b1000, "mie set");
    status_event(1'b1, 1'b0, 1'b0);                 // trap entry
    check_int_en(int_en, 4'b0000, "after trap");
    expect_csr(IDX_MSTATUS, 32'h0000_1880, "mstatus after trap");
    status_event(1'b0, 1'b1, 1'b0);
    check_int_en(int_en, 4'b1000, "after mret");
    expect_csr(IDX_MSTATUS, 32'h0000_1888, "mstatus after mret");
    status_event(1'b1, 1'b0, 1'b1);                 // trap beats the write
    expect_csr(IDX_MSTATUS, 32'h0000_1880, "mstatus trap with write");
    status_event(1'b0, 1'b1, 1'b1);
    expect_csr(IDX_MSTATUS, 32'h0000_1888, "mstatus mret with write");
    drive_write(1'b1, IDX_MSTATUS, 32'h0);
    commit_vs_write(IDX_MEPC);
    commit_vs_write(IDX_MCAUSE);
    commit_vs_write(IDX_MBADADDR);
    end_test("trap_mret", e0);
  endtask

  task automatic irq_step(input irq_t val, input xlen_t old_ip, input xlen_t new_ip);
    irq = val;
    expect_csr(IDX_MIP, old_ip, "mip before edge");
    expect_csr(IDX_MIP, new_ip, "mip one cycle later");
  endtask

  task automatic test_interrupts();
    int      e0;
    xlen_t   d;
    int_en_t exp;
    e0 = err_count;
    irq_step(3'b100, 32'h0, 32'h0000_0800);         // ext
    irq_step(3'b010, 32'h0000_0800, 32'h0000_0008); // sft
    irq_step(3'b001, 32'h0000_0008, 32'h0000_0080); // tmr
    irq_step(3'b111, 32'h0000_0080, 32'h0000_0888);
    irq_step(3'b000, 32'h0000_0888, 32'h0);
    drive_write(1'b1, IDX_MSTATUS, 32'h0);
    repeat (3) begin
      d = $urandom;
      drive_write(1'b1, IDX_MIE, d);
      exp.global_mie = 1'b0;
      exp.meie       = d[11];
      exp.mtie       = d[7];
      exp.msie       = d[3];
      check_int_en(int_en, exp, "mie mirror");
    end
    end_test("interrupts", e0);
  endtask

  task automatic test_counters();
    int    e0;
    int    n_pulse;
    logic  p;
    xlen_t a;
    xlen_t b;
    e0 = err_count;
    drive_write(1'b1, IDX_COUNTERSTOP, 32'h0);
    read_csr(IDX_MCYCLE, a);
    read_csr(IDX_MCYCLE, b);
    check_word(b, a + 32'd1, "mcycle step");
    drive_write(1'b1, IDX_MCYCLE, 32'hFFFF_FFFE);
    drive_write(1'b1, IDX_MCYCLEH, 32'h5);
    expect_csr(IDX_MCYCLEH, 32'h5, "mcycleh before carry");
    expect_csr(IDX_MCYCLEH, 32'h6, "mcycleh after carry");
    expect_csr(IDX_MCYCLE, 32'h1, "mcycle after wrap");
    drive_write(1'b1, IDX_COUNTERSTOP, 32'h1);
    read_csr(IDX_MCYCLE, a);
    read_csr(IDX_MCYCLE, b);
    check_word(b, a, "mcycle frozen");
    drive_write(1'b1, IDX_COUNTERSTOP, 32'h0);
    read_csr(IDX_MINSTRET, a);
    n_pulse = 0;
    for (int i = 0; i < 24; i++) begin
      p = $urandom & 1;
      instret_ena = p;
      n_pulse += p;
      @(negedge clk);
    end
    instret_ena = 1'b0;
    expect_csr(IDX_MINSTRET, a + n_pulse, "minstret pulses");
    drive_write(1'b1, IDX_COUNTERSTOP, 32'h4);
    expect_csr(IDX_COUNTERSTOP, 32'h4, "counterstop");
    check_word(xlen_t'(tm_stop), 32'h0, "tm_stop");
    read_csr(IDX_MINSTRET, a);
    instret_ena = 1'b1;
    repeat (5) @(negedge clk);
    instret_ena = 1'b0;
    expect_csr(IDX_MINSTRET, a, "minstret stopped");
    drive_write(1'b1, IDX_COUNTERSTOP, 32'h0);
    end_test("counters", e0);
  endtask

  initial begin
    void'($urandom(25267));
    rst_n        = 1'b0;
    req          = '0;
    wdata        = '0;
    cmt          = '0;
    instret_ena  = 1'b0;
    irq          = '0;
    core_mhartid = 1'b1;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    test_reset_values();
    test_random_writes();
    test_trap_mret();
    test_interrupts();
    test_counters();
    $display("%0d tests run, %0d with errors, %0d mismatches in total",
             tests_run, tests_bad, err_count);
    if (err_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
